/* Makefile */
BIN := obj_dir/Vtb_phs_avg_top
SRCS := hdl/phs_avg_pkg.sv hdl/iq_interleave.sv hdl/phs_gain_regs.sv \
	hdl/phs_avg.sv hdl/phs_avg_top.sv test/tb_phs_avg_top.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f compile.f \
		--top-module tb_phs_avg_top -Mdir obj_dir

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
hdl/phs_avg_pkg.sv
hdl/iq_interleave.sv
hdl/phs_gain_regs.sv
hdl/phs_avg.sv
hdl/phs_avg_top.sv
test/tb_phs_avg_top.sv

/* hdl/iq_interleave.sv */
`default_nettype none
`timescale 1ns/1ps

// splits one forward/reverse sample pair into two interleaved words
// real parts go out first with iq high, then imaginary parts with iq low
// idle cycles carry zeros so the integrator downstream stays put
module iq_interleave (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        sample_stb,
	input  wire phs_avg_pkg::cplx_t    fwd,
	input  wire phs_avg_pkg::cplx_t    rev,
	output phs_avg_pkg::iq_word_t      word
);

	// captured pair, held while both words go out
	phs_avg_pkg::cplx_t fwd_q;
	phs_avg_pkg::cplx_t rev_q;

	// countdown over the two output phases
	// 2 means real word next, 1 means imaginary word next, 0 is idle
	logic [1:0] phase;

	// strobe only taken while idle
	logic accept;

	// anything arriving during the two output phases is dropped
	assign accept = sample_stb && (phase == 2'd0);

	// sample capture, no reset needed on payload
	always_ff @(posedge clk) begin
		if (accept) begin
			fwd_q <= fwd;
			rev_q <= rev;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 2'd0;
		end else if (accept) begin
			phase <= 2'd2;
		end else if (phase != 2'd0) begin
			phase <= phase - 2'd1;
		end
	end

	// output word register
	// real word lands one edge after acceptance, imaginary one edge later
	always_ff @(posedge clk) begin
		if (reset) begin
			word <= '0;
		end else begin
			case (phase)
				2'd2: begin
					word.iq <= 1'b1;
					word.x <= fwd_q.re;
					word.y <= rev_q.re;
				end
				2'd1: begin
					word.iq <= 1'b0;
					word.x <= fwd_q.im;
					word.y <= rev_q.im;
				end
				default: begin
					// zero fill, iq low
					word <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/phs_avg.sv */
`default_nettype none
`timescale 1ns/1ps

// phase error averager
// each interleaved word is multiplied by the gain looked up one cycle
// earlier, so the real word meets the gains selected while iq was low
// and the imaginary word meets the gains selected while iq was high
// both channels are summed, smoothed by a [1,1] filter and integrated
// latency is four edges from the data word to the first change of z
module phs_avg (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire phs_avg_pkg::iq_word_t          word,
	output logic                                gain_sel,
	input  wire phs_avg_pkg::gain_pair_t        gains,
	output logic signed [phs_avg_pkg::dwi+7:0]  sum_filt,
	output logic signed [phs_avg_pkg::dwi+1:0]  z
);

	// data words as signed multiplier operands
	logic signed [phs_avg_pkg::dwi-1:0] x_word;
	logic signed [phs_avg_pkg::dwi-1:0] y_word;

	// gains held for one cycle
	logic signed [phs_avg_pkg::dwj-1:0] kx_d = '0;
	logic signed [phs_avg_pkg::dwj-1:0] ky_d = '0;

	// full precision products
	logic signed [phs_avg_pkg::dwi+phs_avg_pkg::dwj-1:0] prod_x = '0;
	logic signed [phs_avg_pkg::dwi+phs_avg_pkg::dwj-1:0] prod_y = '0;

	// products with the redundant sign bit and low bits dropped
	logic signed [phs_avg_pkg::dwi+5:0] prod_x_tr;
	logic signed [phs_avg_pkg::dwi+5:0] prod_y_tr;

	// channel sum and its one cycle delayed copy
	logic signed [phs_avg_pkg::dwi+6:0] sum = '0;
	logic signed [phs_avg_pkg::dwi+6:0] sum_d = '0;

	// filter output
	logic signed [phs_avg_pkg::dwi+7:0] sum_f = '0;

	// accumulated phase error
	logic signed [phs_avg_pkg::dwi+7:0] intg;

	// gain lookup follows the iq flag of the current word
	assign gain_sel = word.iq;

	assign x_word = word.x;
	assign y_word = word.y;

	// gain delay and multiply stage
	always_ff @(posedge clk) begin
		kx_d <= gains.kx;
		ky_d <= gains.ky;
		prod_x <= x_word * kx_d;
		prod_y <= y_word * ky_d;
	end

	// keep bits dwi+dwj-2 down to dwi-8
	assign prod_x_tr = prod_x[phs_avg_pkg::dwi+phs_avg_pkg::dwj-2:phs_avg_pkg::dwi-8];
	assign prod_y_tr = prod_y[phs_avg_pkg::dwi+phs_avg_pkg::dwj-2:phs_avg_pkg::dwi-8];

	// channel sum and two tap filter
	always_ff @(posedge clk) begin
		sum <= prod_x_tr + prod_y_tr;
		sum_d <= sum;
		// taps [1, 1]
		sum_f <= sum + sum_d;
	end

	// integrator adds half the filtered value, arithmetic shift floors
	always_ff @(posedge clk) begin
		if (reset) begin
			intg <= '0;
		end else begin
			intg <= intg + (sum_f >>> 1);
		end
	end

	assign sum_filt = sum_f;

	// drop the top guard bit and the five lowest bits
	assign z = intg[phs_avg_pkg::dwi+6:5];

endmodule

`default_nettype wire

/* hdl/phs_avg_pkg.sv */
`default_nettype none

// widths, host register map and bundled signals of the phase averager
package phs_avg_pkg;

	// data word width of the I/Q samples
	localparam int dwi = 17;
	// gain word width
	localparam int dwj = 16;
	// host register address width
	localparam int gain_addr_w = 2;

	// gain register map
	localparam logic [gain_addr_w-1:0] addr_kx_re = 0;
	localparam logic [gain_addr_w-1:0] addr_kx_im = 1;
	localparam logic [gain_addr_w-1:0] addr_ky_re = 2;
	localparam logic [gain_addr_w-1:0] addr_ky_im = 3;

	// one complex baseband sample
	typedef struct packed {
		logic signed [dwi-1:0] re;
		logic signed [dwi-1:0] im;
	} cplx_t;

	// gain word currently selected for each channel
	typedef struct packed {
		logic signed [dwj-1:0] kx;
		logic signed [dwj-1:0] ky;
	} gain_pair_t;

	// single host write, we qualifies the cycle
	typedef struct packed {
		logic we;
		logic [gain_addr_w-1:0] addr;
		logic signed [dwj-1:0] data;
	} cfg_wr_t;

	// interleaved word, real part when iq is high
	typedef struct packed {
		logic iq;
		logic signed [dwi-1:0] x;
		logic signed [dwi-1:0] y;
	} iq_word_t;

endpackage

`default_nettype wire

/* hdl/phs_avg_top.sv */
`default_nettype none
`timescale 1ns/1ps

// phase averager subsystem
// interleaver feeds the averager, the gain block answers its iq lookup
module phs_avg_top (
	input  wire                                clk,
	input  wire                                reset,
	input  wire phs_avg_pkg::cfg_wr_t          cfg,
	output wire signed [phs_avg_pkg::dwj-1:0]  cfg_rdata,
	input  wire                                sample_stb,
	input  wire phs_avg_pkg::cplx_t            fwd,
	input  wire phs_avg_pkg::cplx_t            rev,
	output wire signed [phs_avg_pkg::dwi+1:0]  z,
	output wire signed [phs_avg_pkg::dwi+7:0]  sum_filt
);

	// interleaved forward/reverse words
	wire phs_avg_pkg::iq_word_t word;

	// gain lookup request and reply
	wire gain_sel;
	wire phs_avg_pkg::gain_pair_t gains;

	iq_interleave iq_interleave_inst (
		.clk        (clk),
		.reset      (reset),
		.sample_stb (sample_stb),
		.fwd        (fwd),
		.rev        (rev),
		.word       (word)
	);

	phs_avg phs_avg_inst (
		.clk      (clk),
		.reset    (reset),
		.word     (word),
		.gain_sel (gain_sel),
		.gains    (gains),
		.sum_filt (sum_filt),
		.z        (z)
	);

	// register block steered by the averager's iq flag
	phs_gain_regs phs_gain_regs_inst (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.cfg_rdata (cfg_rdata),
		.gain_sel  (gain_sel),
		.gains     (gains)
	);

endmodule

`default_nettype wire

/* hdl/phs_gain_regs.sv */
`default_nettype none
`timescale 1ns/1ps

// host written complex gains for the forward and reverse channels
// lookup by iq flag and host readback are both combinational
module phs_gain_regs (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire phs_avg_pkg::cfg_wr_t           cfg,
	output logic signed [phs_avg_pkg::dwj-1:0]  cfg_rdata,
	input  wire                                 gain_sel,
	output phs_avg_pkg::gain_pair_t             gains
);

	// forward channel gain
	logic signed [phs_avg_pkg::dwj-1:0] kx_re;
	logic signed [phs_avg_pkg::dwj-1:0] kx_im;
	// reverse channel gain
	logic signed [phs_avg_pkg::dwj-1:0] ky_re;
	logic signed [phs_avg_pkg::dwj-1:0] ky_im;

	// write by address, visible right after the write edge
	always_ff @(posedge clk) begin
		if (reset) begin
			kx_re <= '0;
			kx_im <= '0;
			ky_re <= '0;
			ky_im <= '0;
		end else if (cfg.we) begin
			case (cfg.addr)
				phs_avg_pkg::addr_kx_re: kx_re <= cfg.data;
				phs_avg_pkg::addr_kx_im: kx_im <= cfg.data;
				phs_avg_pkg::addr_ky_re: ky_re <= cfg.data;
				phs_avg_pkg::addr_ky_im: ky_im <= cfg.data;
			endcase
		end
	end

	// host readback of the addressed register
	always_comb begin
		cfg_rdata = '0;
		case (cfg.addr)
			phs_avg_pkg::addr_kx_re: cfg_rdata = kx_re;
			phs_avg_pkg::addr_kx_im: cfg_rdata = kx_im;
			phs_avg_pkg::addr_ky_re: cfg_rdata = ky_re;
			phs_avg_pkg::addr_ky_im: cfg_rdata = ky_im;
			default: cfg_rdata = '0;
		endcase
	end

	// per channel selection
	// gain_sel high picks the imaginary gains, low the real gains
	always_comb begin
		if (gain_sel) begin
			gains.kx = kx_im;
			gains.ky = ky_im;
		end else begin
			gains.kx = kx_re;
			gains.ky = ky_re;
		end
	end

endmodule

`default_nettype wire

/* test/tb_phs_avg_top.sv */
`default_nettype none
`timescale 1ns/1ps

// testbench for the phase averager subsystem
module tb_phs_avg_top;

	// about 230 samples of 9 cycles each and the register traffic, then margin
	localparam int timeout_cycles = 3000;
	localparam int n_zero = 20;
	localparam int n_rand = 200;

	logic clk = 1'b0;
	logic reset;
	phs_avg_pkg::cfg_wr_t cfg;
	logic signed [phs_avg_pkg::dwj-1:0] cfg_rdata;
	logic sample_stb;
	phs_avg_pkg::cplx_t fwd;
	phs_avg_pkg::cplx_t rev;
	logic signed [phs_avg_pkg::dwi+1:0] z;
	logic signed [phs_avg_pkg::dwi+7:0] sum_filt;

	// run bookkeeping
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int checks_issued = 0;
	int checks_done = 0;

	// host view of the gain registers
	logic signed [phs_avg_pkg::dwj-1:0] gain_model [4];
	// model integrator, same width so it wraps the same way
	logic [phs_avg_pkg::dwi+7:0] model_intg;

	// pending checks, cycle due and expected z
	int due_q[$];
	logic [phs_avg_pkg::dwi+1:0] z_exp_q[$];

	phs_avg_top phs_avg_top_inst (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.cfg_rdata  (cfg_rdata),
		.sample_stb (sample_stb),
		.fwd        (fwd),
		.rev        (rev),
		.z          (z),
		.sum_filt   (sum_filt)
	);

	// 40 ns period
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	always @(posedge clk) begin
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// keep product bits dwi+dwj-2 down to dwi-8 as a signed value
	function automatic longint trunc_prod(input longint p);
		logic [63:0] bits;
		logic signed [phs_avg_pkg::dwi+5:0] kept;
		bits = p;
		kept = bits[phs_avg_pkg::dwi+phs_avg_pkg::dwj-2:phs_avg_pkg::dwi-8];
		return longint'(kept);
	endfunction

	// integrator step for one sample
	// gain lookup runs one word ahead so the real word meets the real gains
	// and the imaginary word meets the imaginary gains
	function automatic longint ref_increment(input phs_avg_pkg::cplx_t f,
			input phs_avg_pkg::cplx_t r,
			input logic signed [phs_avg_pkg::dwj-1:0] kx_re,
			input logic signed [phs_avg_pkg::dwj-1:0] kx_im,
			input logic signed [phs_avg_pkg::dwj-1:0] ky_re,
			input logic signed [phs_avg_pkg::dwj-1:0] ky_im);
		longint a;
		longint b;
		a = trunc_prod(longint'($signed(f.re)) * longint'($signed(kx_re)))
			+ trunc_prod(longint'($signed(r.re)) * longint'($signed(ky_re)));
		b = trunc_prod(longint'($signed(f.im)) * longint'($signed(kx_im)))
			+ trunc_prod(longint'($signed(r.im)) * longint'($signed(ky_im)));
		// [1,1] filter taps halved, each term floored
		return (a >>> 1) + ((a + b) >>> 1) + (b >>> 1);
	endfunction

	function automatic phs_avg_pkg::cplx_t make_cplx(input int re, input int im);
		phs_avg_pkg::cplx_t c;
		c.re = re[phs_avg_pkg::dwi-1:0];
		c.im = im[phs_avg_pkg::dwi-1:0];
		return c;
	endfunction

	function automatic phs_avg_pkg::cplx_t rand_cplx();
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = $urandom();
		r1 = $urandom();
		return make_cplx(int'(r0), int'(r1));
	endfunction

	task automatic write_gain(input int addr, input int data);
		@(negedge clk);
		cfg.we = 1'b1;
		cfg.addr = addr[phs_avg_pkg::gain_addr_w-1:0];
		cfg.data = data[phs_avg_pkg::dwj-1:0];
		gain_model[addr] = data[phs_avg_pkg::dwj-1:0];
		@(negedge clk);
		cfg.we = 1'b0;
	endtask

	// readback is combinational, sampled a full cycle after the address
	task automatic check_gain(input int addr);
		@(negedge clk);
		cfg.we = 1'b0;
		cfg.addr = addr[phs_avg_pkg::gain_addr_w-1:0];
		@(negedge clk);
		check_value("cfg_rdata", $unsigned(cfg_rdata), $unsigned(gain_model[addr]));
	endtask

	// one strobe, plus an optional second strobe while the interleaver is busy
	task automatic send_sample(input phs_avg_pkg::cplx_t f, input phs_avg_pkg::cplx_t r,
			input bit extra);
		longint inc;
		inc = ref_increment(f, r, gain_model[phs_avg_pkg::addr_kx_re],
			gain_model[phs_avg_pkg::addr_kx_im], gain_model[phs_avg_pkg::addr_ky_re],
			gain_model[phs_avg_pkg::addr_ky_im]);
		@(negedge clk);
		sample_stb = 1'b1;
		fwd = f;
		rev = r;
		model_intg = model_intg + inc[phs_avg_pkg::dwi+7:0];
		// z settles seven edges after acceptance
		due_q.push_back(cycles + 8);
		z_exp_q.push_back(model_intg[phs_avg_pkg::dwi+6:5]);
		checks_issued++;
		if (extra) begin
			@(negedge clk);
			fwd = rand_cplx();
			rev = rand_cplx();
		end
		@(negedge clk);
		sample_stb = 1'b0;
		while (checks_done != checks_issued) begin
			@(posedge clk);
		end
	endtask

	// compares z against the model once each sample has settled
	always @(negedge clk) begin
		if (due_q.size() != 0 && cycles == due_q[0]) begin
			check_value("z", $unsigned(z), z_exp_q[0]);
			// filter has drained by then
			check_value("sum_filt", $unsigned(sum_filt), 32'd0);
			void'(due_q.pop_front());
			void'(z_exp_q.pop_front());
			checks_done++;
		end
	end

	initial begin
		int i;
		int a;
		int b;
		void'($urandom(32'h778b));
		reset = 1'b1;
		sample_stb = 1'b0;
		cfg = '0;
		fwd = '0;
		rev = '0;
		model_intg = '0;
		for (a = 0; a < 4; a++) begin
			gain_model[a] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// everything cleared
		@(negedge clk);
		check_value("z", $unsigned(z), 32'd0);
		check_value("sum_filt", $unsigned(sum_filt), 32'd0);
		for (a = 0; a < 4; a++) begin
			check_gain(a);
		end
		report_test("reset_state");

		// each write is read back along with the other three
		for (a = 0; a < 4; a++) begin
			write_gain(a, int'($urandom()));
			for (b = 0; b < 4; b++) begin
				check_gain(b);
			end
		end
		report_test("gain_access");

		for (a = 0; a < 4; a++) begin
			write_gain(a, 0);
		end
		for (i = 0; i < n_zero; i++) begin
			send_sample(rand_cplx(), rand_cplx(), 1'b0);
		end
		check_value("z", $unsigned(z), 32'd0);
		report_test("zero_gains");

		write_gain(phs_avg_pkg::addr_kx_re, 16384);
		write_gain(phs_avg_pkg::addr_kx_im, -12000);
		write_gain(phs_avg_pkg::addr_ky_re, -20000);
		write_gain(phs_avg_pkg::addr_ky_im, 9000);
		// pure real, then pure imaginary
		send_sample(make_cplx(50000, 0), make_cplx(-30000, 0), 1'b0);
		send_sample(make_cplx(0, -45000), make_cplx(0, 20000), 1'b0);
		// full negative scale on both channels
		send_sample(make_cplx(-65536, -65536), make_cplx(-65536, -65536), 1'b0);
		// most negative gains too, product top bit falls outside the kept slice
		for (a = 0; a < 4; a++) begin
			write_gain(a, -32768);
		end
		send_sample(make_cplx(-65536, -65536), make_cplx(-65536, -65536), 1'b0);
		report_test("directed");

		for (i = 0; i < n_rand; i++) begin
			if (i % 50 == 0) begin
				for (a = 0; a < 4; a++) begin
					write_gain(a, int'($urandom()));
				end
			end
			send_sample(rand_cplx(), rand_cplx(), i == 120);
		end
		report_test("random");

		$display("checks %0d, errors %0d, tests 5", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
